//--- project.f
common/cpu_pkg.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
design/reg_file.sv
design/cpu_top.sv
verification/cpu_chk.sv
verification/cpu_tb.sv

//--- Makefile
TOP := cpu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)
	verilator --lint-only -f project.f --top-module cpu_top

obj_dir/V$(TOP): project.f
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- verification/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

    import cpu_pkg::*;

    localparam int NUM_ENTRIES = 9;
    localparam int CLK_PERIOD  = 40;

    logic  clk;
    logic  rst_n_i;
    logic  stall_i;
    word_t inst_i;
    addr_t inst_addr_o;
    opr_t  ldst_data_i = '0;
    opr_t  ldst_data_o;
    addr_t ldst_addr_o;
    logic  ldst_write_o;
    logic  hlt_o;

    word_t imem [256];
    opr_t  dmem [256];

    // test table
    opcode_e     tbl_op [NUM_ENTRIES];
    logic [15:0] tbl_a  [NUM_ENTRIES];
    logic [15:0] tbl_b  [NUM_ENTRIES];
    logic        tbl_br [NUM_ENTRIES];

    cpu_top i_cpu_top (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .inst_i       (inst_i),
        .inst_addr_o  (inst_addr_o),
        .ldst_data_i  (ldst_data_i),
        .ldst_data_o  (ldst_data_o),
        .ldst_addr_o  (ldst_addr_o),
        .ldst_write_o (ldst_write_o),
        .hlt_o        (hlt_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign inst_i = imem[inst_addr_o];

    // data memory answers one cycle after the address
    always @(posedge clk) begin
        if (ldst_write_o) begin
            dmem[ldst_addr_o] <= ldst_data_o;
        end
        ldst_data_i <= dmem[ldst_addr_o];
    end

    task automatic check_equal(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // no store while stalled or halted
    always @(negedge clk) begin
        if (rst_n_i) begin
            check_equal(16'(ldst_write_o && (stall_i || hlt_o)), 16'h0,
                        "store pulse while stalled or halted");
        end
    end

    function automatic word_t enc(input opcode_e op, input int rd, input int rs0,
                                  input int rs1);
        enc = {4'(op), 4'(rd), 4'(rs0), 4'(rs1)};
    endfunction

    function automatic word_t enci(input opcode_e op, input int rd, input logic [7:0] imm);
        enci = {4'(op), 4'(rd), imm};
    endfunction

    task automatic load_program(input int n);
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc(NOP, 0, 0, 0);
            dmem[i] = 16'(i * 16'h0101) ^ 16'h5a00;
        end
        dmem[8'h10] = tbl_a[n];
        dmem[8'h11] = tbl_b[n];
        imem[0] = enci(LI, 2, 8'h10);
        imem[1] = enc(LD, 3, 2, 0);
        imem[2] = enci(LI, 4, 8'h11);
        imem[3] = enc(LD, 5, 4, 0);
        if (tbl_op[n] == LI) begin
            imem[4] = enci(LI, 6, tbl_b[n][7:0]);
            imem[5] = imem[4];
        end else if (tbl_op[n] == ADDI) begin
            imem[4] = enc(ADD, 6, 3, 0);
            imem[5] = enci(ADDI, 6, tbl_b[n][7:0]);
        end else begin
            // first copy uses r5 right after its load
            imem[4] = enc(tbl_op[n], 6, 3, 5);
            imem[5] = imem[4];
        end
        imem[6]  = enc(ADD, 7, 6, 3);
        imem[7]  = enci(LI, 8, 8'h20);
        imem[8]  = enc(ST, 0, 8, 6);
        imem[9]  = enci(LI, 9, 8'h21);
        imem[10] = enc(ST, 0, 9, 7);
        imem[11] = enci(LI, 10, 8'h30);
        imem[12] = enci(BEQZ, tbl_br[n] ? 0 : 6, 8'd2);
        imem[13] = enc(ST, 0, 10, 3);
        imem[14] = enci(JMP, 0, 8'd16);
        imem[15] = enc(ST, 0, 10, 5);
        imem[16] = enci(HLT, 0, 8'h00);
        // store to 0x31 that must never happen
        imem[17] = enci(LI, 10, 8'h31);
        imem[18] = enc(ST, 0, 10, 6);
    endtask

    task automatic apply_reset;
        @(posedge clk);
        rst_n_i <= 1'b0;
        stall_i <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_equal(16'(hlt_o), 16'h0, "hlt_o after reset");
        check_equal(16'(inst_addr_o), 16'h0, "pc after reset");
    endtask

    task automatic run_entry(input int n, input logic with_stalls);
        logic [15:0] res;
        logic        halted;
        load_program(n);
        apply_reset();
        halted = 1'b0;
        while (!halted) begin
            @(posedge clk);
            stall_i <= with_stalls ? ($urandom_range(0, 3) == 0) : 1'b0;
            @(negedge clk);
            halted = hlt_o;
        end
        @(posedge clk);
        stall_i <= 1'b0;
        repeat (4) @(negedge clk);
        check_equal(16'(hlt_o), 16'h1, "hlt_o stays high");
        // reference model from the ISA rules
        case (tbl_op[n])
            ADD:     res = tbl_a[n] + tbl_b[n];
            SUB:     res = tbl_a[n] - tbl_b[n];
            AND:     res = tbl_a[n] & tbl_b[n];
            OR:      res = tbl_a[n] | tbl_b[n];
            XOR:     res = tbl_a[n] ^ tbl_b[n];
            LI:      res = {8'h00, tbl_b[n][7:0]};
            default: res = tbl_a[n] + {{8{tbl_b[n][7]}}, tbl_b[n][7:0]};
        endcase
        check_equal(dmem[8'h20], res, $sformatf("entry %0d result", n));
        check_equal(dmem[8'h21], res + tbl_a[n], $sformatf("entry %0d chained sum", n));
        check_equal(dmem[8'h30], (tbl_br[n] || res == 16'h0) ? tbl_b[n] : tbl_a[n],
                    $sformatf("entry %0d branch path", n));
        check_equal(dmem[8'h31], 16'h3131 ^ 16'h5a00,
                    $sformatf("entry %0d store after halt", n));
    endtask

    initial begin
        #(NUM_ENTRIES * 200 * CLK_PERIOD);
        $display("Timeout: the processor did not halt in time");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        void'($urandom(94691));
        tbl_op = '{ADD, SUB, AND, OR, XOR, LI, ADDI, ADDI, SUB};
        tbl_a  = '{16'h1234, 16'h0005, 16'hff00, 16'h8001, 16'haaaa,
                   16'h0000, 16'h0100, 16'h7fff, 16'h1000};
        tbl_b  = '{16'h0f0f, 16'h0005, 16'h0ff0, 16'h0110, 16'haaaa,
                   16'h0080, 16'h00ff, 16'h0001, 16'h2000};
        tbl_br = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            run_entry(n, 1'b0);
            run_entry(n, 1'b1);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- verification/cpu_chk.sv
`timescale 1ns/100ps

module cpu_chk (
    input logic clk,
    input logic rst_n_i,
    input logic stall_i,
    input logic ldst_write_i,
    input logic hlt_i
);

    // stores are blocked by a global stall
    store_during_stall: assert property (@(posedge clk) stall_i |-> !ldst_write_i)
        else $error("store pulse while stall_i is high");

    // pipeline is empty once reset has been seen
    store_during_reset: assert property (@(posedge clk) !rst_n_i |=> !ldst_write_i)
        else $error("store pulse during reset");

    // halt is sticky
    halt_sticky: assert property (@(posedge clk) (hlt_i && rst_n_i) |=> hlt_i)
        else $error("hlt_o fell without reset");

    store_single_pulse: assert property (@(posedge clk) ldst_write_i |=> !ldst_write_i)
        else $error("ldst_write_o high for two cycles");

endmodule

bind cpu_top cpu_chk i_cpu_chk (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall_i),
    .ldst_write_i (ldst_write_o),
    .hlt_i        (hlt_o)
);

//--- design/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           stall_i,
    input  cpu_pkg::word_t inst_i,
    output cpu_pkg::addr_t inst_addr_o,
    input  cpu_pkg::opr_t  ldst_data_i,
    output cpu_pkg::opr_t  ldst_data_o,
    output cpu_pkg::addr_t ldst_addr_o,
    output logic           ldst_write_o,
    output logic           hlt_o
);

    import cpu_pkg::*;

    // fetch - decode
    logic     fd_valid;
    word_t    fd_inst;
    addr_t    fd_pc;
    logic     df_stall;

    // decode - register file
    reg_idx_t rd_idx0;
    reg_idx_t rd_idx1;
    opr_t     rd_data0;
    opr_t     rd_data1;
    logic     rd_resv0;
    logic     rd_resv1;
    logic     reserve_en;
    reg_idx_t reserve_idx;

    // decode - execute
    logic     de_valid;
    opcode_e  de_op;
    opr_t     de_opr0;
    opr_t     de_opr1;
    imm_t     de_imm;
    addr_t    de_pc;
    reg_idx_t de_wb_idx;
    logic     ed_stall;

    // execute back to the other blocks
    logic     wb_en;
    reg_idx_t wb_idx;
    opr_t     wb_data;
    logic     branch_taken;
    addr_t    branch_addr;

    fetch_stage u_fetch (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall_i),
        .df_stall_i     (df_stall),
        .branch_taken_i (branch_taken),
        .branch_addr_i  (branch_addr),
        .inst_i         (inst_i),
        .inst_addr_o    (inst_addr_o),
        .fd_valid_o     (fd_valid),
        .fd_inst_o      (fd_inst),
        .fd_pc_o        (fd_pc)
    );

    decode_stage u_decode (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall_i),
        .fd_valid_i     (fd_valid),
        .fd_inst_i      (fd_inst),
        .fd_pc_i        (fd_pc),
        .df_stall_o     (df_stall),
        .rd_idx0_o      (rd_idx0),
        .rd_idx1_o      (rd_idx1),
        .rd_data0_i     (rd_data0),
        .rd_data1_i     (rd_data1),
        .rd_resv0_i     (rd_resv0),
        .rd_resv1_i     (rd_resv1),
        .reserve_en_o   (reserve_en),
        .reserve_idx_o  (reserve_idx),
        .wb_en_i        (wb_en),
        .wb_idx_i       (wb_idx),
        .wb_data_i      (wb_data),
        .branch_taken_i (branch_taken),
        .ed_stall_i     (ed_stall),
        .de_valid_o     (de_valid),
        .de_op_o        (de_op),
        .de_opr0_o      (de_opr0),
        .de_opr1_o      (de_opr1),
        .de_imm_o       (de_imm),
        .de_pc_o        (de_pc),
        .de_wb_idx_o    (de_wb_idx)
    );

    reg_file u_reg_file (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .rd_idx0_i     (rd_idx0),
        .rd_idx1_i     (rd_idx1),
        .rd_data0_o    (rd_data0),
        .rd_data1_o    (rd_data1),
        .rd_resv0_o    (rd_resv0),
        .rd_resv1_o    (rd_resv1),
        .reserve_en_i  (reserve_en),
        .reserve_idx_i (reserve_idx),
        .wb_en_i       (wb_en),
        .wb_idx_i      (wb_idx),
        .wb_data_i     (wb_data)
    );

    execute_stage u_execute (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall_i),
        .de_valid_i     (de_valid),
        .de_op_i        (de_op),
        .de_opr0_i      (de_opr0),
        .de_opr1_i      (de_opr1),
        .de_imm_i       (de_imm),
        .de_pc_i        (de_pc),
        .de_wb_idx_i    (de_wb_idx),
        .ed_stall_o     (ed_stall),
        .wb_en_o        (wb_en),
        .wb_idx_o       (wb_idx),
        .wb_data_o      (wb_data),
        .branch_taken_o (branch_taken),
        .branch_addr_o  (branch_addr),
        .ldst_addr_o    (ldst_addr_o),
        .ldst_write_o   (ldst_write_o),
        .ldst_data_o    (ldst_data_o),
        .ldst_data_i    (ldst_data_i),
        .hlt_o          (hlt_o)
    );

endmodule

//--- design/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n_i,
    input  cpu_pkg::reg_idx_t rd_idx0_i,
    input  cpu_pkg::reg_idx_t rd_idx1_i,
    output cpu_pkg::opr_t     rd_data0_o,
    output cpu_pkg::opr_t     rd_data1_o,
    output logic              rd_resv0_o,
    output logic              rd_resv1_o,
    input  logic              reserve_en_i,
    input  cpu_pkg::reg_idx_t reserve_idx_i,
    input  logic              wb_en_i,
    input  cpu_pkg::reg_idx_t wb_idx_i,
    input  cpu_pkg::opr_t     wb_data_i
);

    import cpu_pkg::*;

    opr_t                regs_q [NUM_REGS];
    logic [NUM_REGS-1:0] resv_q;

    // asynchronous read ports
    assign rd_data0_o = regs_q[rd_idx0_i];
    assign rd_data1_o = regs_q[rd_idx1_i];
    assign rd_resv0_o = resv_q[rd_idx0_i];
    assign rd_resv1_o = resv_q[rd_idx1_i];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_en_i) begin
            regs_q[wb_idx_i] <= wb_data_i;
        end
    end

    // a new reservation beats a writeback to the same register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            resv_q <= '0;
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (reserve_en_i && reserve_idx_i == reg_idx_t'(i)) begin
                    resv_q[i] <= 1'b1;
                end else if (wb_en_i && wb_idx_i == reg_idx_t'(i)) begin
                    resv_q[i] <= 1'b0;
                end
            end
        end
    end

endmodule

//--- execute/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              de_valid_i,
    input  cpu_pkg::opcode_e  de_op_i,
    input  cpu_pkg::opr_t     de_opr0_i,
    input  cpu_pkg::opr_t     de_opr1_i,
    input  cpu_pkg::imm_t     de_imm_i,
    input  cpu_pkg::addr_t    de_pc_i,
    input  cpu_pkg::reg_idx_t de_wb_idx_i,
    output logic              ed_stall_o,
    output logic              wb_en_o,
    output cpu_pkg::reg_idx_t wb_idx_o,
    output cpu_pkg::opr_t     wb_data_o,
    output logic              branch_taken_o,
    output cpu_pkg::addr_t    branch_addr_o,
    output cpu_pkg::addr_t    ldst_addr_o,
    output logic              ldst_write_o,
    output cpu_pkg::opr_t     ldst_data_o,
    input  cpu_pkg::opr_t     ldst_data_i,
    output logic              hlt_o
);

    import cpu_pkg::*;

    exec_state_e state_q;
    exec_state_e state_d;
    reg_idx_t    load_idx_q;
    addr_t       load_addr_q;
    logic        run;
    logic        alu_wr;
    opr_t        alu_res;
    opr_t        imm_sext;
    opr_t        imm_zext;

    assign run      = (state_q == EX_RUN) && de_valid_i && !stall_i;
    assign imm_sext = {{(OPR_W - IMM_W){de_imm_i[IMM_W-1]}}, de_imm_i};
    assign imm_zext = {{(OPR_W - IMM_W){1'b0}}, de_imm_i};

    always_comb begin
        alu_res = '0;
        alu_wr  = 1'b1;
        case (de_op_i)
            ADD:     alu_res = de_opr0_i + de_opr1_i;
            SUB:     alu_res = de_opr0_i - de_opr1_i;
            AND:     alu_res = de_opr0_i & de_opr1_i;
            OR:      alu_res = de_opr0_i | de_opr1_i;
            XOR:     alu_res = de_opr0_i ^ de_opr1_i;
            LI:      alu_res = imm_zext;
            ADDI:    alu_res = de_opr0_i + imm_sext;
            default: alu_wr  = 1'b0;
        endcase
    end

    // 8-bit add wraps like the sign-extended offset would
    always_comb begin
        branch_taken_o = 1'b0;
        branch_addr_o  = addr_t'(de_imm_i);
        if (run && de_op_i == JMP) begin
            branch_taken_o = 1'b1;
        end else if (run && de_op_i == BEQZ) begin
            branch_taken_o = (de_opr0_i == '0);
            branch_addr_o  = de_pc_i + addr_t'(1) + addr_t'(de_imm_i);
        end
    end

    // load data returns in EX_LOAD
    always_comb begin
        if (state_q == EX_LOAD) begin
            wb_en_o   = !stall_i;
            wb_idx_o  = load_idx_q;
            wb_data_o = ldst_data_i;
        end else begin
            wb_en_o   = run && alu_wr;
            wb_idx_o  = de_wb_idx_i;
            wb_data_o = alu_res;
        end
    end

    // address held through the wait so a stall keeps the read stable
    assign ldst_addr_o  = (state_q == EX_LOAD) ? load_addr_q : de_opr0_i[ADDR_W-1:0];
    assign ldst_write_o = run && (de_op_i == ST);
    assign ldst_data_o  = de_opr1_i;
    assign ed_stall_o   = (state_q == EX_LOAD);
    assign hlt_o        = (state_q == EX_HALT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            EX_RUN: begin
                if (run && de_op_i == LD) begin
                    state_d = EX_LOAD;
                end else if (run && de_op_i == HLT) begin
                    state_d = EX_HALT;
                end
            end
            EX_LOAD: begin
                if (!stall_i) begin
                    state_d = EX_RUN;
                end
            end
            // halt is left only through reset
            default: state_d = state_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= EX_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (run && de_op_i == LD) begin
            load_idx_q  <= de_wb_idx_i;
            load_addr_q <= de_opr0_i[ADDR_W-1:0];
        end
    end

endmodule

//--- decode/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              fd_valid_i,
    input  cpu_pkg::word_t    fd_inst_i,
    input  cpu_pkg::addr_t    fd_pc_i,
    output logic              df_stall_o,
    output cpu_pkg::reg_idx_t rd_idx0_o,
    output cpu_pkg::reg_idx_t rd_idx1_o,
    input  cpu_pkg::opr_t     rd_data0_i,
    input  cpu_pkg::opr_t     rd_data1_i,
    input  logic              rd_resv0_i,
    input  logic              rd_resv1_i,
    output logic              reserve_en_o,
    output cpu_pkg::reg_idx_t reserve_idx_o,
    input  logic              wb_en_i,
    input  cpu_pkg::reg_idx_t wb_idx_i,
    input  cpu_pkg::opr_t     wb_data_i,
    input  logic              branch_taken_i,
    input  logic              ed_stall_i,
    output logic              de_valid_o,
    output cpu_pkg::opcode_e  de_op_o,
    output cpu_pkg::opr_t     de_opr0_o,
    output cpu_pkg::opr_t     de_opr1_o,
    output cpu_pkg::imm_t     de_imm_o,
    output cpu_pkg::addr_t    de_pc_o,
    output cpu_pkg::reg_idx_t de_wb_idx_o
);

    import cpu_pkg::*;

    opcode_e  op;
    reg_idx_t dst_idx;
    logic     use0;
    logic     use1;
    logic     writes_dst;
    logic     fwd0;
    logic     fwd1;
    logic     hazard;
    logic     issue;
    logic     load_en;
    opr_t     opr0;
    opr_t     opr1;

    // unused opcodes decode as nop
    always_comb begin
        op = opcode_e'(fd_inst_i[OP_HI:OP_LO]);
        if (fd_inst_i[OP_HI:OP_LO] > HLT) begin
            op = NOP;
        end
    end

    assign dst_idx = fd_inst_i[RD_HI:RD_LO];

    // BEQZ and ADDI take their register from the rd field
    assign rd_idx0_o = (op == BEQZ || op == ADDI) ? dst_idx : fd_inst_i[RS0_HI:RS0_LO];
    assign rd_idx1_o = fd_inst_i[RS1_HI:RS1_LO];

    always_comb begin
        use0       = 1'b0;
        use1       = 1'b0;
        writes_dst = 1'b0;
        case (op)
            ADD, SUB, AND, OR, XOR: begin
                use0       = 1'b1;
                use1       = 1'b1;
                writes_dst = 1'b1;
            end
            LI: writes_dst = 1'b1;
            ADDI, LD: begin
                use0       = 1'b1;
                writes_dst = 1'b1;
            end
            ST: begin
                use0 = 1'b1;
                use1 = 1'b1;
            end
            BEQZ: use0 = 1'b1;
            default: writes_dst = 1'b0;
        endcase
    end

    // writeback in flight overrides the register file read
    assign fwd0 = wb_en_i && (wb_idx_i == rd_idx0_o);
    assign fwd1 = wb_en_i && (wb_idx_i == rd_idx1_o);
    assign opr0 = fwd0 ? wb_data_i : rd_data0_i;
    assign opr1 = fwd1 ? wb_data_i : rd_data1_i;

    assign hazard = fd_valid_i
                 && ((use0 && rd_resv0_i && !fwd0) || (use1 && rd_resv1_i && !fwd1));

    assign df_stall_o    = hazard || ed_stall_i;
    assign issue         = fd_valid_i && !df_stall_o && !stall_i && !branch_taken_i;
    assign reserve_en_o  = issue && writes_dst;
    assign reserve_idx_o = dst_idx;
    assign load_en       = !stall_i && !ed_stall_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            de_valid_o <= 1'b0;
        end else if (load_en) begin
            de_valid_o <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            de_op_o     <= op;
            de_opr0_o   <= opr0;
            de_opr1_o   <= opr1;
            de_imm_o    <= fd_inst_i[IMM_HI:IMM_LO];
            de_pc_o     <= fd_pc_i;
            de_wb_idx_o <= dst_idx;
        end
    end

endmodule

//--- fetch/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           stall_i,
    input  logic           df_stall_i,
    input  logic           branch_taken_i,
    input  cpu_pkg::addr_t branch_addr_i,
    input  cpu_pkg::word_t inst_i,
    output cpu_pkg::addr_t inst_addr_o,
    output logic           fd_valid_o,
    output cpu_pkg::word_t fd_inst_o,
    output cpu_pkg::addr_t fd_pc_o
);

    import cpu_pkg::*;

    addr_t pc_q;
    logic  advance;

    // instruction memory is read combinationally at the current pc
    assign inst_addr_o = pc_q;

    assign advance = !stall_i && !df_stall_i && !branch_taken_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q       <= '0;
            fd_valid_o <= 1'b0;
        end else if (!stall_i) begin
            if (branch_taken_i) begin
                // redirect, the word fetched this cycle is dropped
                pc_q       <= branch_addr_i;
                fd_valid_o <= 1'b0;
            end else if (!df_stall_i) begin
                pc_q       <= pc_q + addr_t'(1);
                fd_valid_o <= 1'b1;
            end
        end
    end

    // instruction and its pc for decode
    always_ff @(posedge clk) begin
        if (advance) begin
            fd_inst_o <= inst_i;
            fd_pc_o   <= pc_q;
        end
    end

endmodule

//--- common/cpu_pkg.sv
package cpu_pkg;

    localparam int WORD_W    = 16;
    localparam int ADDR_W    = 8;
    localparam int OPR_W     = 16;
    localparam int REG_IDX_W = 4;
    localparam int IMM_W     = 8;
    localparam int NUM_REGS  = 16;

    // instruction field positions
    localparam int OP_HI  = 15;
    localparam int OP_LO  = 12;
    localparam int RD_HI  = 11;
    localparam int RD_LO  = 8;
    localparam int RS0_HI = 7;
    localparam int RS0_LO = 4;
    localparam int RS1_HI = 3;
    localparam int RS1_LO = 0;
    // imm overlaps rs0 and rs1
    localparam int IMM_HI = 7;
    localparam int IMM_LO = 0;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [OPR_W-1:0]     opr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;

    typedef enum logic [3:0] {
        NOP  = 4'h0,
        ADD  = 4'h1,
        SUB  = 4'h2,
        AND  = 4'h3,
        OR   = 4'h4,
        XOR  = 4'h5,
        LI   = 4'h6,
        ADDI = 4'h7,
        LD   = 4'h8,
        ST   = 4'h9,
        BEQZ = 4'ha,
        JMP  = 4'hb,
        HLT  = 4'hc
    } opcode_e;

    // execute sequencer
    typedef enum logic [1:0] {
        EX_RUN,
        EX_LOAD,
        EX_HALT
    } exec_state_e;

endpackage
